// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing -Wno-fatal -j 0
TOP   := issue_tb
FLIST := verilog.f
BUILD := obj_dir
LOG   := sim.log

SRCS  := $(wildcard hw/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/issue_pkg.sv ====
//////////////////////////////////////////////////
// pl_type_e needs 3 bits to hold its five classes
// unit bit order is fixed: branch is bit 0
//////////////////////////////////////////////////
`default_nettype none

package issue_pkg;

  // data and register widths
  localparam int unsigned XLEN      = 32;
  localparam int unsigned REG_AW    = 5;
  localparam int unsigned NUM_REGS  = 32;

  // EX pipelines offering forwarded data
  localparam int unsigned NUM_FWD_PL = 4;

  // issue targets and their bit positions in a unit-select vector
  localparam int unsigned NUM_UNITS = 5;
  localparam int unsigned UNIT_BR   = 0;
  localparam int unsigned UNIT_ALU0 = 1;
  localparam int unsigned UNIT_ALU1 = 2;
  localparam int unsigned UNIT_LS   = 3;
  localparam int unsigned UNIT_MULT = 4;

  localparam int unsigned PL_TYPE_W = 3;

  typedef enum logic [PL_TYPE_W-1:0] {
    PL_NONE   = 3'd0,
    PL_BRANCH = 3'd1,
    PL_ALU    = 3'd2,
    PL_LS     = 3'd3,
    PL_MULT   = 3'd4
  } pl_type_e;

  // one-hot select of the issue target
  typedef logic [NUM_UNITS-1:0] unit_sel_t;

  // every unit except the branch unit
  localparam unit_sel_t EX_UNITS = ~(unit_sel_t'(1) << UNIT_BR);

  typedef struct packed {
    pl_type_e            pl_type;
    logic [REG_AW-1:0]   rs1;
    logic [REG_AW-1:0]   rs2;
    logic [1:0]          rf_ren;
    logic [REG_AW-1:0]   rd;
    logic                rf_we;
    logic [XLEN-1:0]     pc;
  } ir_dec_t;

  // forwarding offer of one EX pipeline, two write ports
  typedef struct packed {
    logic [1:0]          valid;
    logic [REG_AW-1:0]   addr0;
    logic [XLEN-1:0]     data0;
    logic [REG_AW-1:0]   addr1;
    logic [XLEN-1:0]     data1;
  } pl_fwd_t;

  typedef struct packed {
    logic [XLEN-1:0]     d0;
    logic [XLEN-1:0]     d1;
  } op_pair_t;

  typedef struct packed {
    unit_sel_t           pl;
    logic [XLEN-1:0]     pc;
  } sbd_entry_t;

endpackage

`default_nettype wire

// ==== hw/issue_top.sv ====
//////////////////////////////////////////////////
// purely combinational except the reservation bits
// ex_rdy_i order: alu0, alu1, ls, mult
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module issue_top (
  input  wire logic                                              clk_i,
  input  wire logic                                              rst_ni,

  // instruction register
  input  wire issue_pkg::ir_dec_t                                ira_dec_i,
  input  wire issue_pkg::ir_dec_t                                irb_dec_i,
  input  wire logic                                              ira_is0_i,
  input  wire logic [1:0]                                        ir_valid_i,
  output      logic [1:0]                                        issuer_rdy_o,

  // EX pipelines
  input  wire logic [issue_pkg::NUM_FWD_PL-1:0]                  ex_rdy_i,
  output      issue_pkg::unit_sel_t                              ex_valid_o,
  output      logic                                              ls_sel_ira_o,
  output      logic                                              mult_sel_ira_o,
  input  wire issue_pkg::pl_fwd_t [issue_pkg::NUM_FWD_PL-1:0]    fwd_info_i,
  input  wire logic [issue_pkg::NUM_FWD_PL-1:0][issue_pkg::NUM_REGS-1:0] fwd_act_i,

  // commit and scoreboard FIFO
  input  wire logic [1:0]                                        sbd_wr_rdy_i,
  output      logic [1:0]                                        sbd_wr_valid_o,
  output      issue_pkg::sbd_entry_t                             sbd_wdata0_o,
  output      issue_pkg::sbd_entry_t                             sbd_wdata1_o,
  input  wire logic [issue_pkg::NUM_REGS-1:0]                    cmt_regwr_i,
  input  wire logic                                              cmt_flush_i,

  // register file
  input  wire issue_pkg::op_pair_t                               ira_rf_rdata_i,
  input  wire issue_pkg::op_pair_t                               irb_rf_rdata_i,
  output      issue_pkg::op_pair_t                               ira_fwd_data_o,
  output      issue_pkg::op_pair_t                               irb_fwd_data_o
);

  issue_pkg::ir_dec_t ir0_dec;
  issue_pkg::ir_dec_t ir1_dec;
  logic [1:0]         issued;
  logic [1:0]         hazard;

  pipe_select u_sel (
    .ira_dec_i      (ira_dec_i),
    .irb_dec_i      (irb_dec_i),
    .ira_is0_i      (ira_is0_i),
    .ir_valid_i     (ir_valid_i),
    .hazard_i       (hazard),
    .ex_rdy_i       (ex_rdy_i),
    .sbd_wr_rdy_i   (sbd_wr_rdy_i),
    .ir0_dec_o      (ir0_dec),
    .ir1_dec_o      (ir1_dec),
    .issued_o       (issued),
    .ex_valid_o     (ex_valid_o),
    .issuer_rdy_o   (issuer_rdy_o),
    .ls_sel_ira_o   (ls_sel_ira_o),
    .mult_sel_ira_o (mult_sel_ira_o),
    .sbd_wr_valid_o (sbd_wr_valid_o),
    .sbd_wdata0_o   (sbd_wdata0_o),
    .sbd_wdata1_o   (sbd_wdata1_o)
  );

  reg_reserve u_rsv (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ir0_dec_i   (ir0_dec),
    .ir1_dec_i   (ir1_dec),
    .issued_i    (issued),
    .cmt_regwr_i (cmt_regwr_i),
    .cmt_flush_i (cmt_flush_i),
    .fwd_act_i   (fwd_act_i),
    .hazard_o    (hazard)
  );

  operand_fwd u_fwd (
    .ira_dec_i      (ira_dec_i),
    .irb_dec_i      (irb_dec_i),
    .ira_rf_rdata_i (ira_rf_rdata_i),
    .irb_rf_rdata_i (irb_rf_rdata_i),
    .fwd_info_i     (fwd_info_i),
    .ira_fwd_data_o (ira_fwd_data_o),
    .irb_fwd_data_o (irb_fwd_data_o)
  );

endmodule

`default_nettype wire

// ==== hw/operand_fwd.sv ====
//////////////////////////////////////////////////
// several matching offers are ORed together
// x0 reads zero whatever the offers say
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module operand_fwd (
  input  wire issue_pkg::ir_dec_t                             ira_dec_i,
  input  wire issue_pkg::ir_dec_t                             irb_dec_i,
  input  wire issue_pkg::op_pair_t                            ira_rf_rdata_i,
  input  wire issue_pkg::op_pair_t                            irb_rf_rdata_i,
  input  wire issue_pkg::pl_fwd_t [issue_pkg::NUM_FWD_PL-1:0] fwd_info_i,
  output      issue_pkg::op_pair_t                            ira_fwd_data_o,
  output      issue_pkg::op_pair_t                            irb_fwd_data_o
);

  // one operand: forwarded data if any pipeline offers it, else regfile
  function automatic logic [issue_pkg::XLEN-1:0] fwd_lookup(
      logic [issue_pkg::REG_AW-1:0]                    addr,
      logic [issue_pkg::XLEN-1:0]                      rf_data,
      issue_pkg::pl_fwd_t [issue_pkg::NUM_FWD_PL-1:0]  info);
    logic                       hit;
    logic [issue_pkg::XLEN-1:0] fwd_data;
    logic [issue_pkg::XLEN-1:0] result;

    hit      = 1'b0;
    fwd_data = '0;
    for (int p = 0; p < issue_pkg::NUM_FWD_PL; p++) begin
      if (info[p].valid[0] && (info[p].addr0 == addr)) begin
        hit      = 1'b1;
        fwd_data = fwd_data | info[p].data0;
      end
      if (info[p].valid[1] && (info[p].addr1 == addr)) begin
        hit      = 1'b1;
        fwd_data = fwd_data | info[p].data1;
      end
    end

    if (addr == '0) begin
      result = '0;
    end else begin
      result = hit ? fwd_data : rf_data;
    end
    return result;
  endfunction

  assign ira_fwd_data_o.d0 = fwd_lookup(ira_dec_i.rs1, ira_rf_rdata_i.d0, fwd_info_i);
  assign ira_fwd_data_o.d1 = fwd_lookup(ira_dec_i.rs2, ira_rf_rdata_i.d1, fwd_info_i);
  assign irb_fwd_data_o.d0 = fwd_lookup(irb_dec_i.rs1, irb_rf_rdata_i.d0, fwd_info_i);
  assign irb_fwd_data_o.d1 = fwd_lookup(irb_dec_i.rs2, irb_rf_rdata_i.d1, fwd_info_i);

endmodule

`default_nettype wire

// ==== hw/pipe_select.sv ====
//////////////////////////////////////////////////
// ir1 only issues behind ir0, never alone
// ex_valid_o is a request; units act on it only when ready
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pipe_select (
  input  wire issue_pkg::ir_dec_t                ira_dec_i,
  input  wire issue_pkg::ir_dec_t                irb_dec_i,
  input  wire logic                              ira_is0_i,
  input  wire logic [1:0]                        ir_valid_i,
  input  wire logic [1:0]                        hazard_i,
  input  wire logic [issue_pkg::NUM_FWD_PL-1:0]  ex_rdy_i,
  input  wire logic [1:0]                        sbd_wr_rdy_i,
  output      issue_pkg::ir_dec_t                ir0_dec_o,
  output      issue_pkg::ir_dec_t                ir1_dec_o,
  output      logic [1:0]                        issued_o,
  output      issue_pkg::unit_sel_t              ex_valid_o,
  output      logic [1:0]                        issuer_rdy_o,
  output      logic                              ls_sel_ira_o,
  output      logic                              mult_sel_ira_o,
  output      logic [1:0]                        sbd_wr_valid_o,
  output      issue_pkg::sbd_entry_t             sbd_wdata0_o,
  output      issue_pkg::sbd_entry_t             sbd_wdata1_o
);

  // map an instruction class to its target unit
  function automatic issue_pkg::unit_sel_t select_unit(logic en, logic from_a,
                                                      issue_pkg::pl_type_e pl_type);
    issue_pkg::unit_sel_t sel;

    sel = '0;
    if (en) begin
      case (pl_type)
        issue_pkg::PL_BRANCH: sel[issue_pkg::UNIT_BR]   = 1'b1;
        issue_pkg::PL_ALU:    sel[from_a ? issue_pkg::UNIT_ALU0 : issue_pkg::UNIT_ALU1] = 1'b1;
        issue_pkg::PL_LS:     sel[issue_pkg::UNIT_LS]   = 1'b1;
        issue_pkg::PL_MULT:   sel[issue_pkg::UNIT_MULT] = 1'b1;
        default:              sel = '0;
      endcase
    end
    return sel;
  endfunction

  issue_pkg::unit_sel_t ex_rdy;
  issue_pkg::unit_sel_t ir0_sel, ir1_sel;
  logic [1:0]           sel_en;
  logic [1:0]           issued;
  logic [1:0]           fifo_wr;

  // program order
  assign ir0_dec_o = ira_is0_i ? ira_dec_i : irb_dec_i;
  assign ir1_dec_o = ira_is0_i ? irb_dec_i : ira_dec_i;

  // branch unit sits in bit 0 and never stalls
  assign ex_rdy = {ex_rdy_i, 1'b1};

  assign sel_en[0] = ir_valid_i[0] & ~hazard_i[0] & sbd_wr_rdy_i[0];
  assign ir0_sel   = select_unit(sel_en[0], ira_is0_i, ir0_dec_o.pl_type);

  // a selected unit is busy for ir1 if ir0 already took it
  assign sel_en[1] = issued[0] & ir_valid_i[1] & ~hazard_i[1] & sbd_wr_rdy_i[1];
  assign ir1_sel   = select_unit(sel_en[1], ~ira_is0_i, ir1_dec_o.pl_type) &
                     ~(ir0_sel & issue_pkg::EX_UNITS);

  // issued once every selected unit is ready
  assign issued[0] = (|ir0_sel) && ((ir0_sel & ex_rdy) == ir0_sel);
  assign issued[1] = (|ir1_sel) && ((ir1_sel & ex_rdy) == ir1_sel);

  assign issued_o     = issued;
  assign issuer_rdy_o = issued;
  assign ex_valid_o   = ir0_sel | ir1_sel;

  // EX input muxes take slot a unless slot b is the one going there
  assign ls_sel_ira_o = (ira_is0_i && (ira_dec_i.pl_type == issue_pkg::PL_LS)) ||
                        (!ira_is0_i && (irb_dec_i.pl_type != issue_pkg::PL_LS));
  assign mult_sel_ira_o = (ira_is0_i && (ira_dec_i.pl_type == issue_pkg::PL_MULT)) ||
                          (!ira_is0_i && (irb_dec_i.pl_type != issue_pkg::PL_MULT));

  // branches resolve in the branch unit and skip the commit FIFO
  assign fifo_wr[0] = issued[0] & (|(ir0_sel & issue_pkg::EX_UNITS));
  assign fifo_wr[1] = issued[1] & (|(ir1_sel & issue_pkg::EX_UNITS));

  assign sbd_wr_valid_o[0] = |fifo_wr;
  assign sbd_wr_valid_o[1] = &fifo_wr;

  // entry 0 always carries the older written instruction
  assign sbd_wdata0_o.pl = fifo_wr[0] ? ir0_sel : ir1_sel;
  assign sbd_wdata0_o.pc = fifo_wr[0] ? ir0_dec_o.pc : ir1_dec_o.pc;
  assign sbd_wdata1_o.pl = ir1_sel;
  assign sbd_wdata1_o.pc = ir1_dec_o.pc;

endmodule

`default_nettype wire

// ==== hw/reg_reserve.sv ====
//////////////////////////////////////////////////
// write-after-write is allowed, only RaW stalls
// a flush drops every reservation at the next edge
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module reg_reserve (
  input  wire logic                                                      clk_i,
  input  wire logic                                                      rst_ni,
  input  wire issue_pkg::ir_dec_t                                        ir0_dec_i,
  input  wire issue_pkg::ir_dec_t                                        ir1_dec_i,
  input  wire logic [1:0]                                                issued_i,
  input  wire logic [issue_pkg::NUM_REGS-1:0]                            cmt_regwr_i,
  input  wire logic                                                      cmt_flush_i,
  input  wire logic [issue_pkg::NUM_FWD_PL-1:0][issue_pkg::NUM_REGS-1:0] fwd_act_i,
  output      logic [1:0]                                                hazard_o
);

  localparam int unsigned NR = issue_pkg::NUM_REGS;

  // register address to one-hot request, x0 never requests
  function automatic logic [NR-1:0] reg_bit(logic en, logic [issue_pkg::REG_AW-1:0] addr);
    logic [NR-1:0] vec;

    vec = '0;
    if (en && (addr != '0)) begin
      vec[addr] = 1'b1;
    end
    return vec;
  endfunction

  logic [NR-1:1] rsv_q;
  logic [NR-1:0] rsv_nxt;
  logic [NR-1:0] set_vec;
  logic [NR-1:0] ir0_rd_req, ir1_rd_req;
  logic [NR-1:0] ir0_wr_req, ir1_wr_req;
  logic [NR-1:0] ir0_rsv, ir1_rsv;
  logic [NR-1:0] fwd_any, ir1_fwd;
  logic          wr_conflict;

  assign ir0_rd_req = reg_bit(ir0_dec_i.rf_ren[0], ir0_dec_i.rs1) |
                      reg_bit(ir0_dec_i.rf_ren[1], ir0_dec_i.rs2);
  assign ir1_rd_req = reg_bit(ir1_dec_i.rf_ren[0], ir1_dec_i.rs1) |
                      reg_bit(ir1_dec_i.rf_ren[1], ir1_dec_i.rs2);
  assign ir0_wr_req = reg_bit(ir0_dec_i.rf_we, ir0_dec_i.rd);
  assign ir1_wr_req = reg_bit(ir1_dec_i.rf_we, ir1_dec_i.rd);

  // any pipeline that can hand the value over removes the stall
  always_comb begin
    fwd_any = '0;
    for (int p = 0; p < issue_pkg::NUM_FWD_PL; p++) begin
      fwd_any = fwd_any | fwd_act_i[p];
    end
  end

  assign ir0_rsv = {rsv_q, 1'b0};

  // ir0 writes before ir1 reads, and that value is not in any EX stage yet
  assign ir1_rsv = ir0_rsv | ir0_wr_req;
  assign ir1_fwd = fwd_any & ~ir0_wr_req;

  // same destination in one pair is serialized
  assign wr_conflict = |(ir0_wr_req & ir1_wr_req);

  assign hazard_o[0] = |(ir0_rsv & ~fwd_any & ir0_rd_req);
  assign hazard_o[1] = (|(ir1_rsv & ~ir1_fwd & ir1_rd_req)) | wr_conflict;

  // a new issue wins over a commit of the same register
  assign set_vec = ({NR{issued_i[0]}} & ir0_wr_req) | ({NR{issued_i[1]}} & ir1_wr_req);
  assign rsv_nxt = (ir0_rsv & ~cmt_regwr_i) | set_vec;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_q <= '0;
    end else if (cmt_flush_i) begin
      rsv_q <= '0;
    end else begin
      rsv_q <= rsv_nxt[NR-1:1];
    end
  end

endmodule

`default_nettype wire

// ==== sim/issue_checker.sv ====
//////////////////////////////////////////////////
// samples 1 ns before each rising edge (8 ns clock)
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module issue_checker (
  input  wire logic                  clk_i,
  input  wire logic                  check_en_i,
  input  wire logic                  done_i,
  input  wire logic                  timeout_i,
  input  wire logic [8*12-1:0]       name_i,
  input  wire issue_pkg::unit_sel_t  exp_ev_i,
  input  wire logic [1:0]            exp_rdy_i,
  input  wire logic [1:0]            exp_sv_i,
  input  wire issue_pkg::op_pair_t   exp_fwd_i,
  input  wire issue_pkg::op_pair_t   exp_fwd_b_i,
  input  wire issue_pkg::sbd_entry_t exp_w0_i,
  input  wire issue_pkg::sbd_entry_t exp_w1_i,
  // bit 0 ls input from slot a, bit 1 mult input from slot a
  input  wire logic [1:0]            exp_isel_i,
  input  wire issue_pkg::unit_sel_t  ex_valid_i,
  input  wire logic [1:0]            issuer_rdy_i,
  input  wire logic [1:0]            sbd_wr_valid_i,
  input  wire issue_pkg::op_pair_t   fwd_data_i,
  input  wire issue_pkg::op_pair_t   fwd_b_i,
  input  wire issue_pkg::sbd_entry_t wdata0_i,
  input  wire issue_pkg::sbd_entry_t wdata1_i,
  input  wire logic                  ls_sel_ira_i,
  input  wire logic                  mult_sel_ira_i,
  output      int unsigned           err_cnt_o
);

  localparam int unsigned SAMPLE_DLY = 7;

  int unsigned n_checks;
  int unsigned n_mismatch;

  assign err_cnt_o = n_mismatch + (timeout_i ? 32'd1 : 32'd0);

  task automatic check_field(input string field, input logic [63:0] exp,
                             input logic [63:0] act);
    n_checks++;
    if (exp !== act) begin
      n_mismatch++;
      $display("mismatch %0s %0s: expected %0h, actual %0h", name_i, field, exp, act);
    end
  endtask

  initial begin
    n_checks   = 0;
    n_mismatch = 0;
    forever begin
      @(posedge clk_i);
      #SAMPLE_DLY;
      if (check_en_i) begin
        check_field("ex_valid", 64'(exp_ev_i), 64'(ex_valid_i));
        check_field("issuer_rdy", 64'(exp_rdy_i), 64'(issuer_rdy_i));
        check_field("sbd_wr_valid", 64'(exp_sv_i), 64'(sbd_wr_valid_i));
        check_field("fwd_data", 64'(exp_fwd_i), 64'(fwd_data_i));
        check_field("fwd_data_b", 64'(exp_fwd_b_i), 64'(fwd_b_i));
        // entries and input selects only matter where they are used
        if (exp_sv_i[0]) begin
          check_field("sbd_wdata0", 64'(exp_w0_i), 64'(wdata0_i));
        end
        if (exp_sv_i[1]) begin
          check_field("sbd_wdata1", 64'(exp_w1_i), 64'(wdata1_i));
        end
        if (exp_ev_i[issue_pkg::UNIT_LS]) begin
          check_field("ls_sel_ira", 64'(exp_isel_i[0]), 64'(ls_sel_ira_i));
        end
        if (exp_ev_i[issue_pkg::UNIT_MULT]) begin
          check_field("mult_sel_ira", 64'(exp_isel_i[1]), 64'(mult_sel_ira_i));
        end
      end
    end
  end

  always @(posedge done_i) begin
    $display("checks %0d, mismatches %0d, timeouts %0d", n_checks, n_mismatch, timeout_i);
  end

endmodule

`default_nettype wire

// ==== sim/issue_tb.sv ====
//////////////////////////////////////////////////
// one table row per clock, slot a older unless set
// fifo entries and input selects checked only when in use
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module issue_tb;

  localparam int unsigned NAME_W   = 8 * 12;
  localparam int unsigned HALF_PER = 4;
  localparam int unsigned RST_CYC  = 16;
  localparam int unsigned DRV_DLY  = 1;
  localparam logic [31:0] RNG_SEED = 32'hc704;

  localparam issue_pkg::pl_type_e NONE = issue_pkg::PL_NONE;
  localparam issue_pkg::pl_type_e BR   = issue_pkg::PL_BRANCH;
  localparam issue_pkg::pl_type_e ALU  = issue_pkg::PL_ALU;
  localparam issue_pkg::pl_type_e LS   = issue_pkg::PL_LS;
  localparam issue_pkg::pl_type_e MUL  = issue_pkg::PL_MULT;

  typedef struct packed {
    logic [NAME_W-1:0]                  name;
    issue_pkg::ir_dec_t                 a;
    issue_pkg::ir_dec_t                 b;
    logic                               is0;
    logic [1:0]                         valid;
    logic [issue_pkg::NUM_FWD_PL-1:0]   ex_rdy;
    logic [issue_pkg::NUM_REGS-1:0]     act;
    logic [issue_pkg::NUM_REGS-1:0]     cmt;
    logic                               flush;
    issue_pkg::pl_fwd_t                 offer;
    // bit 0 takes d0 from the offer, bit 1 takes d1, same for both slots
    logic [1:0]                         fwd_kind;
    issue_pkg::op_pair_t                rf_a;
    issue_pkg::op_pair_t                rf_b;
    issue_pkg::unit_sel_t               exp_ev;
    logic [1:0]                         exp_rdy;
    logic [1:0]                         exp_sv;
    issue_pkg::op_pair_t                exp_fwd;
    issue_pkg::op_pair_t                exp_fwd_b;
    // unit of the younger instruction when both are written
    issue_pkg::unit_sel_t               exp_pl1;
    issue_pkg::sbd_entry_t              exp_w0;
    issue_pkg::sbd_entry_t              exp_w1;
    // bit 0 ls input from slot a, bit 1 mult input from slot a
    logic [1:0]                         exp_isel;
  } row_t;

  row_t        rows [32];
  int unsigned n_rows;
  int unsigned limit;
  int unsigned err_cnt;
  logic        check_en;
  logic        done;
  logic        timed_out;

  logic                                                   clk_i;
  logic                                                   rst_ni;
  issue_pkg::ir_dec_t                                     ira_dec_i;
  issue_pkg::ir_dec_t                                     irb_dec_i;
  logic                                                   ira_is0_i;
  logic [1:0]                                             ir_valid_i;
  logic [1:0]                                             issuer_rdy_o;
  logic [issue_pkg::NUM_FWD_PL-1:0]                       ex_rdy_i;
  issue_pkg::unit_sel_t                                   ex_valid_o;
  logic                                                   ls_sel_ira_o;
  logic                                                   mult_sel_ira_o;
  issue_pkg::pl_fwd_t [issue_pkg::NUM_FWD_PL-1:0]         fwd_info_i;
  logic [issue_pkg::NUM_FWD_PL-1:0][issue_pkg::NUM_REGS-1:0] fwd_act_i;
  logic [1:0]                                             sbd_wr_rdy_i;
  logic [1:0]                                             sbd_wr_valid_o;
  issue_pkg::sbd_entry_t                                  sbd_wdata0_o;
  issue_pkg::sbd_entry_t                                  sbd_wdata1_o;
  logic [issue_pkg::NUM_REGS-1:0]                         cmt_regwr_i;
  logic                                                   cmt_flush_i;
  issue_pkg::op_pair_t                                    ira_rf_rdata_i;
  issue_pkg::op_pair_t                                    irb_rf_rdata_i;
  issue_pkg::op_pair_t                                    ira_fwd_data_o;
  issue_pkg::op_pair_t                                    irb_fwd_data_o;

  logic [NAME_W-1:0]     chk_name;
  issue_pkg::unit_sel_t  chk_ev;
  logic [1:0]            chk_rdy;
  logic [1:0]            chk_sv;
  issue_pkg::op_pair_t   chk_fwd;
  issue_pkg::op_pair_t   chk_fwd_b;
  issue_pkg::sbd_entry_t chk_w0;
  issue_pkg::sbd_entry_t chk_w1;
  logic [1:0]            chk_isel;

  issue_top dut (.*);

  issue_checker u_chk (
    .clk_i          (clk_i),
    .check_en_i     (check_en),
    .done_i         (done),
    .timeout_i      (timed_out),
    .name_i         (chk_name),
    .exp_ev_i       (chk_ev),
    .exp_rdy_i      (chk_rdy),
    .exp_sv_i       (chk_sv),
    .exp_fwd_i      (chk_fwd),
    .exp_fwd_b_i    (chk_fwd_b),
    .exp_w0_i       (chk_w0),
    .exp_w1_i       (chk_w1),
    .exp_isel_i     (chk_isel),
    .ex_valid_i     (ex_valid_o),
    .issuer_rdy_i   (issuer_rdy_o),
    .sbd_wr_valid_i (sbd_wr_valid_o),
    .fwd_data_i     (ira_fwd_data_o),
    .fwd_b_i        (irb_fwd_data_o),
    .wdata0_i       (sbd_wdata0_o),
    .wdata1_i       (sbd_wdata1_o),
    .ls_sel_ira_i   (ls_sel_ira_o),
    .mult_sel_ira_i (mult_sel_ira_o),
    .err_cnt_o      (err_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PER clk_i = ~clk_i;
  end

  // decoded instruction, rd of 0 means no register write
  function automatic issue_pkg::ir_dec_t instr(issue_pkg::pl_type_e t, int rd, int rs1,
                                               int rs2);
    issue_pkg::ir_dec_t d;

    d         = '0;
    d.pl_type = t;
    d.rd      = 5'(rd);
    d.rf_we   = (rd != 0);
    d.rs1     = 5'(rs1);
    d.rs2     = 5'(rs2);
    d.rf_ren  = (t != NONE) ? 2'b11 : 2'b00;
    return d;
  endfunction

  // operand pair a slot should see for the given offer pattern
  function automatic issue_pkg::op_pair_t expected_pair(issue_pkg::op_pair_t rf,
                                                        issue_pkg::ir_dec_t d,
                                                        logic [1:0] kind,
                                                        issue_pkg::pl_fwd_t offer);
    issue_pkg::op_pair_t p;

    p = rf;
    if (kind[0]) begin
      p.d0 = offer.data0;
    end
    if (kind[1]) begin
      p.d1 = offer.data1;
    end
    // x0 reads zero even when an offer matches
    if (d.rs1 == '0) begin
      p.d0 = '0;
    end
    if (d.rs2 == '0) begin
      p.d1 = '0;
    end
    return p;
  endfunction

  // exp packs {ex_valid, issuer_rdy, sbd_wr_valid}
  task automatic add_row(input logic [NAME_W-1:0] name, input issue_pkg::ir_dec_t a,
                         input issue_pkg::ir_dec_t b, input logic [1:0] valid,
                         input logic [8:0] exp);
    row_t r;

    r        = '0;
    r.name   = name;
    r.a      = a;
    r.b      = b;
    r.is0    = 1'b1;
    r.valid  = valid;
    r.ex_rdy = '1;
    {r.exp_ev, r.exp_rdy, r.exp_sv} = exp;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic add_offer(input logic [1:0] valid, input int addr0, input int addr1,
                           input logic [1:0] kind);
    rows[n_rows-1].offer.valid = valid;
    rows[n_rows-1].offer.addr0 = 5'(addr0);
    rows[n_rows-1].offer.addr1 = 5'(addr1);
    rows[n_rows-1].fwd_kind    = kind;
  endtask

  task automatic build_table();
    issue_pkg::ir_dec_t nop;

    nop    = instr(NONE, 0, 0, 0);
    n_rows = 0;
    // unit choice by type and slot
    add_row("alu_a", instr(ALU, 1, 2, 3), nop, 2'b01, 9'b00010_01_01);
    add_row("alu_b_older", nop, instr(ALU, 4, 5, 6), 2'b01, 9'b00100_01_01);
    rows[n_rows-1].is0 = 1'b0;
    add_row("ls_mult", instr(LS, 7, 8, 12), instr(MUL, 9, 10, 11), 2'b11, 9'b11000_11_11);
    rows[n_rows-1].exp_pl1  = 5'b10000;
    rows[n_rows-1].exp_isel = 2'b01;
    add_row("branch", instr(BR, 0, 12, 13), nop, 2'b01, 9'b00001_01_00);
    // dual issue
    add_row("dual_alu", instr(ALU, 14, 15, 16), instr(ALU, 17, 18, 19), 2'b11,
            9'b00110_11_11);
    rows[n_rows-1].exp_pl1 = 5'b00100;
    add_row("dual_ls", instr(LS, 20, 21, 22), instr(LS, 23, 24, 25), 2'b11, 9'b01000_01_01);
    rows[n_rows-1].exp_isel = 2'b01;
    // multiply pipeline not ready, then ready
    add_row("bp_hold", instr(MUL, 26, 27, 28), nop, 2'b01, 9'b10000_00_00);
    rows[n_rows-1].ex_rdy   = 4'b0111;
    rows[n_rows-1].exp_isel = 2'b10;
    add_row("bp_go", instr(MUL, 26, 27, 28), nop, 2'b01, 9'b10000_01_01);
    rows[n_rows-1].exp_isel = 2'b10;
    // x1, x4 and x7 are reserved by the rows above
    add_row("raw_stall", instr(ALU, 29, 1, 2), nop, 2'b01, 9'b00000_00_00);
    add_row("raw_fwd", instr(ALU, 29, 1, 2), nop, 2'b01, 9'b00010_01_01);
    rows[n_rows-1].act = 32'h1 << 1;
    add_row("raw_cmt", instr(ALU, 30, 4, 5), nop, 2'b01, 9'b00000_00_00);
    rows[n_rows-1].cmt = 32'h1 << 4;
    add_row("raw_cmt_clr", instr(ALU, 30, 4, 5), nop, 2'b01, 9'b00010_01_01);
    add_row("raw_flush", instr(ALU, 31, 7, 8), nop, 2'b01, 9'b00000_00_00);
    rows[n_rows-1].flush = 1'b1;
    add_row("raw_flsh_clr", instr(ALU, 31, 7, 8), nop, 2'b01, 9'b00010_01_01);
    add_row("waw_pair", instr(ALU, 3, 5, 6), instr(ALU, 3, 8, 10), 2'b11, 9'b00010_01_01);
    // forwarding, offer on x5 valid, offer on x6 not valid
    add_row("fwd_hit", instr(BR, 0, 5, 6), instr(BR, 0, 5, 6), 2'b01, 9'b00001_01_00);
    add_offer(2'b01, 5, 6, 2'b01);
    add_row("fwd_x0", instr(BR, 0, 0, 6), instr(BR, 0, 0, 6), 2'b01, 9'b00001_01_00);
    add_offer(2'b11, 0, 6, 2'b10);
    limit = n_rows * 4 + 40;
  endtask

  task automatic fill_random();
    for (int unsigned i = 0; i < n_rows; i++) begin
      rows[i].a.pc        = $urandom();
      rows[i].b.pc        = $urandom();
      rows[i].rf_a        = {$urandom(), $urandom()};
      rows[i].rf_b        = {$urandom(), $urandom()};
      rows[i].offer.data0 = $urandom();
      rows[i].offer.data1 = $urandom();
      rows[i].exp_fwd     = expected_pair(rows[i].rf_a, rows[i].a, rows[i].fwd_kind,
                                          rows[i].offer);
      rows[i].exp_fwd_b   = expected_pair(rows[i].rf_b, rows[i].b, rows[i].fwd_kind,
                                          rows[i].offer);
      // entry 0 is the older written instruction, entry 1 the younger
      rows[i].exp_w0.pl   = rows[i].exp_ev & issue_pkg::EX_UNITS & ~rows[i].exp_pl1;
      rows[i].exp_w0.pc   = rows[i].is0 ? rows[i].a.pc : rows[i].b.pc;
      rows[i].exp_w1.pl   = rows[i].exp_pl1;
      rows[i].exp_w1.pc   = rows[i].is0 ? rows[i].b.pc : rows[i].a.pc;
    end
  endtask

  task automatic drive_idle();
    rst_ni         = 1'b0;
    ira_dec_i      = '0;
    irb_dec_i      = '0;
    ira_is0_i      = 1'b1;
    ir_valid_i     = '0;
    ex_rdy_i       = '1;
    fwd_info_i     = '0;
    fwd_act_i      = '0;
    sbd_wr_rdy_i   = 2'b11;
    cmt_regwr_i    = '0;
    cmt_flush_i    = 1'b0;
    ira_rf_rdata_i = '0;
    irb_rf_rdata_i = '0;
    check_en       = 1'b0;
    done           = 1'b0;
    timed_out      = 1'b0;
    chk_name       = '0;
    chk_ev         = '0;
    chk_rdy        = '0;
    chk_sv         = '0;
    chk_fwd        = '0;
    chk_fwd_b      = '0;
    chk_w0         = '0;
    chk_w1         = '0;
    chk_isel       = '0;
  endtask

  task automatic end_run();
    done = 1'b1;
    #1;
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin : main
    void'($urandom(RNG_SEED));
    drive_idle();
    build_table();
    fill_random();
    repeat (RST_CYC) @(posedge clk_i);
    #DRV_DLY;
    rst_ni = 1'b1;
    for (int unsigned i = 0; i < n_rows; i++) begin
      @(posedge clk_i);
      #DRV_DLY;
      ira_dec_i      = rows[i].a;
      irb_dec_i      = rows[i].b;
      ira_is0_i      = rows[i].is0;
      ir_valid_i     = rows[i].valid;
      ex_rdy_i       = rows[i].ex_rdy;
      // offers come from pipeline 2, forwardable registers from pipeline 3
      fwd_info_i[2]  = rows[i].offer;
      fwd_act_i[3]   = rows[i].act;
      cmt_regwr_i    = rows[i].cmt;
      cmt_flush_i    = rows[i].flush;
      ira_rf_rdata_i = rows[i].rf_a;
      irb_rf_rdata_i = rows[i].rf_b;
      chk_name       = rows[i].name;
      chk_ev         = rows[i].exp_ev;
      chk_rdy        = rows[i].exp_rdy;
      chk_sv         = rows[i].exp_sv;
      chk_fwd        = rows[i].exp_fwd;
      chk_fwd_b      = rows[i].exp_fwd_b;
      chk_w0         = rows[i].exp_w0;
      chk_w1         = rows[i].exp_w1;
      chk_isel       = rows[i].exp_isel;
      check_en       = 1'b1;
    end
    @(posedge clk_i);
    #DRV_DLY;
    check_en = 1'b0;
    end_run();
  end

  initial begin : watchdog
    int unsigned cycles;

    cycles = 0;
    // the table and its limit are set up at time zero
    @(posedge clk_i);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    timed_out = 1'b1;
    $display("timeout: the run did not end within %0d cycles", limit);
    end_run();
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/issue_pkg.sv
hw/operand_fwd.sv
hw/reg_reserve.sv
hw/pipe_select.sv
hw/issue_top.sv
sim/issue_checker.sv
sim/issue_tb.sv
